/* include/hist_cfg.svh */
`ifndef HIST_CFG_SVH
`define HIST_CFG_SVH

// pixels served by one histogram block
`define HIST_PIXELS 4

// time bins per pixel
`define HIST_BINS 16

// counter width, counts saturate at all ones
`define HIST_COUNT_W 6

// end-of-acquisition markers per histogram
`define HIST_ACQ_NUM 3

// front end word width
`define HIST_WORD_W 12

// address widths, must cover HIST_PIXELS and HIST_BINS
`define HIST_PIXEL_W 2
`define HIST_BIN_W 4

`endif

/* src/hist_word_pkg.sv */
`default_nettype none

`include "hist_cfg.svh"

package hist_word_pkg;

    // event view with the kind bit low
    // pixel and bin select the counter to bump
    typedef struct packed {
        logic                                             kind;
        logic [`HIST_PIXEL_W-1:0]                         pixel;
        logic [`HIST_BIN_W-1:0]                           bin;
        logic [`HIST_WORD_W-2-`HIST_PIXEL_W-`HIST_BIN_W:0] pad;
    } hist_event_t;

    // marker view with the kind bit high
    typedef struct packed {
        logic                     kind;
        logic [2:0]               code;
        logic [`HIST_WORD_W-5:0]  pad;
    } hist_marker_t;

    // one front end word
    // kind sits at the msb in both views
    typedef union packed {
        hist_event_t  evt;
        hist_marker_t mrk;
    } hist_word_u;

    // marker codes
    // anything else is ignored
    localparam logic [2:0] MARK_ACQ_END = 3'd0;
    localparam logic [2:0] MARK_FLUSH   = 3'd1;

endpackage

`default_nettype wire

/* src/hist_op_pkg.sv */
`default_nettype none

`include "hist_cfg.svh"

package hist_op_pkg;

    // decoded operation kinds
    typedef enum logic [1:0] {
        OP_NONE,
        OP_INC,
        OP_ACQ_END,
        OP_FLUSH
    } hist_op_e;

    // decode -> execute
    // pixel and bin only meaningful for OP_INC
    typedef struct packed {
        hist_op_e                 op;
        logic [`HIST_PIXEL_W-1:0] pixel;
        logic [`HIST_BIN_W-1:0]   bin;
    } hist_op_t;

    // one readout entry of a completed histogram
    typedef struct packed {
        logic                     valid;
        logic [`HIST_PIXEL_W-1:0] pixel;
        logic [`HIST_BIN_W-1:0]   bin;
        logic [`HIST_COUNT_W-1:0] count;
    } hist_rd_t;

endpackage

`default_nettype wire

/* src/hist_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module hist_decode
    import hist_word_pkg::*, hist_op_pkg::*;
(
    input  logic       clk,
    input  logic       res,
    input  logic       word_strobe,
    input  hist_word_u word,
    output hist_op_t   op
);

    hist_op_t op_next;

    always_comb begin
        // idle unless a word is strobed
        op_next.op    = OP_NONE;
        op_next.pixel = '0;
        op_next.bin   = '0;
        if (word_strobe) begin
            if (!word.evt.kind) begin
                // timing event
                op_next.op    = OP_INC;
                op_next.pixel = word.evt.pixel;
                op_next.bin   = word.evt.bin;
            end else begin
                // control marker, unknown codes dropped
                case (word.mrk.code)
                    MARK_ACQ_END: op_next.op = OP_ACQ_END;
                    MARK_FLUSH:   op_next.op = OP_FLUSH;
                    default:      op_next.op = OP_NONE;
                endcase
            end
        end
    end

    // one op per cycle, one cycle after the strobe
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            op <= '0;
        end else begin
            op <= op_next;
        end
    end

endmodule

`default_nettype wire

/* src/hist_execute.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hist_cfg.svh"

module hist_execute
    import hist_op_pkg::*;
(
    input  logic                     clk,
    input  logic                     res,
    input  hist_op_t                 op,
    input  logic                     rd_en,
    input  logic [`HIST_PIXEL_W-1:0] rd_addr_pixel,
    input  logic [`HIST_BIN_W-1:0]   rd_addr_bin,
    output logic [`HIST_COUNT_W-1:0] rd_count,
    output logic                     rd_start,
    output logic                     hist_num,
    output logic                     hist_drop
);

    localparam int ACQ_W = $clog2(`HIST_ACQ_NUM + 1);

    // two ping-pong banks, hist_num selects the one being filled
    logic [`HIST_COUNT_W-1:0] bank [2][`HIST_PIXELS][`HIST_BINS];

    logic [ACQ_W-1:0] acq_cnt;
    logic             rd_busy;
    logic             rd_bank;
    logic             acq_done;
    logic             swap_due;
    logic             do_swap;
    logic             do_drop;
    logic             rd_final;

    // readout always targets the bank not being filled
    assign rd_bank  = ~hist_num;
    assign rd_count = bank[rd_bank][rd_addr_pixel][rd_addr_bin];

    // last acquisition of this histogram
    assign acq_done = (op.op == OP_ACQ_END) &&
                      (acq_cnt == ACQ_W'(`HIST_ACQ_NUM - 1));
    assign swap_due = acq_done || (op.op == OP_FLUSH);

    // previous readout still running -> discard instead of swap
    assign do_swap = swap_due && !rd_busy;
    assign do_drop = swap_due && rd_busy;

    // final entry fetched, readout done at this edge
    assign rd_final = rd_en &&
                      (rd_addr_pixel == `HIST_PIXEL_W'(`HIST_PIXELS - 1)) &&
                      (rd_addr_bin == `HIST_BIN_W'(`HIST_BINS - 1));

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            acq_cnt   <= '0;
            rd_busy   <= 1'b0;
            rd_start  <= 1'b0;
            hist_num  <= 1'b0;
            hist_drop <= 1'b0;
        end else begin
            // single cycle pulses
            rd_start  <= do_swap;
            hist_drop <= do_drop;
            if (do_swap) begin
                hist_num <= ~hist_num;
            end
            // acquisition count restarts on swap and on drop
            if (swap_due) begin
                acq_cnt <= '0;
            end else if (op.op == OP_ACQ_END) begin
                acq_cnt <= acq_cnt + 1'b1;
            end
            // busy from swap edge through the last fetch
            if (do_swap) begin
                rd_busy <= 1'b1;
            end else if (rd_final) begin
                rd_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int p = 0; p < `HIST_PIXELS; p++) begin
                for (int b = 0; b < `HIST_BINS; b++) begin
                    bank[0][p][b] <= '0;
                    bank[1][p][b] <= '0;
                end
            end
        end else begin
            if (do_drop) begin
                // wipe the histogram being filled
                for (int p = 0; p < `HIST_PIXELS; p++) begin
                    for (int b = 0; b < `HIST_BINS; b++) begin
                        bank[hist_num][p][b] <= '0;
                    end
                end
            end else if (op.op == OP_INC &&
                         bank[hist_num][op.pixel][op.bin] != '1) begin
                // saturating increment
                bank[hist_num][op.pixel][op.bin] <= bank[hist_num][op.pixel][op.bin] + 1'b1;
            end
            // read and clear, leaves the bank empty for the next fill
            if (rd_en) begin
                bank[rd_bank][rd_addr_pixel][rd_addr_bin] <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* src/hist_result.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hist_cfg.svh"

module hist_result
    import hist_op_pkg::*;
(
    input  logic                     clk,
    input  logic                     res,
    input  logic                     rd_start,
    input  logic [`HIST_COUNT_W-1:0] rd_count,
    output logic                     rd_en,
    output logic [`HIST_PIXEL_W-1:0] rd_addr_pixel,
    output logic [`HIST_BIN_W-1:0]   rd_addr_bin,
    output hist_rd_t                 out_entry,
    output logic                     out_last
);

    localparam int IDX_W = `HIST_PIXEL_W + `HIST_BIN_W;
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(`HIST_PIXELS * `HIST_BINS - 1);

    logic             run;
    logic [IDX_W-1:0] idx;
    logic             idx_last;

    // pixel-major walk, bins ascending
    assign rd_en                        = run;
    assign {rd_addr_pixel, rd_addr_bin} = idx;
    assign idx_last                     = (idx == IDX_LAST);

    // address sequencer
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            run <= 1'b0;
            idx <= '0;
        end else if (rd_start) begin
            run <= 1'b1;
            idx <= '0;
        end else if (run) begin
            idx <= idx + 1'b1;
            if (idx_last) begin
                run <= 1'b0;
            end
        end
    end

    // output stage, count paired with its address
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            out_entry <= '0;
            out_last  <= 1'b0;
        end else begin
            out_entry.valid <= run;
            out_entry.pixel <= rd_addr_pixel;
            out_entry.bin   <= rd_addr_bin;
            out_entry.count <= rd_count;
            out_last        <= run && idx_last;
        end
    end

endmodule

`default_nettype wire

/* src/hist_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hist_cfg.svh"

module hist_top
    import hist_word_pkg::*, hist_op_pkg::*;
(
    input  logic       clk,
    input  logic       res,
    input  logic       word_strobe,
    input  hist_word_u word,
    output hist_rd_t   out_entry,
    output logic       out_last,
    output logic       hist_num,
    output logic       hist_drop
);

    hist_op_t                 op;
    logic                     rd_start;
    logic                     rd_en;
    logic [`HIST_PIXEL_W-1:0] rd_addr_pixel;
    logic [`HIST_BIN_W-1:0]   rd_addr_bin;
    logic [`HIST_COUNT_W-1:0] rd_count;

    // word -> op
    hist_decode i_hist_decode (
        .clk         (clk),
        .res         (res),
        .word_strobe (word_strobe),
        .word        (word),
        .op          (op)
    );

    // banks, swap and drop control
    hist_execute i_hist_execute (
        .clk           (clk),
        .res           (res),
        .op            (op),
        .rd_en         (rd_en),
        .rd_addr_pixel (rd_addr_pixel),
        .rd_addr_bin   (rd_addr_bin),
        .rd_count      (rd_count),
        .rd_start      (rd_start),
        .hist_num      (hist_num),
        .hist_drop     (hist_drop)
    );

    // readout stream
    hist_result i_hist_result (
        .clk           (clk),
        .res           (res),
        .rd_start      (rd_start),
        .rd_count      (rd_count),
        .rd_en         (rd_en),
        .rd_addr_pixel (rd_addr_pixel),
        .rd_addr_bin   (rd_addr_bin),
        .out_entry     (out_entry),
        .out_last      (out_last)
    );

endmodule

`default_nettype wire

/* tests/hist_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module hist_chk
    import hist_op_pkg::*;
(
    input  logic     clk,
    input  logic     res,
    input  hist_rd_t out_entry,
    input  logic     out_last,
    input  logic     hist_num,
    input  logic     hist_drop
);

    // last marker only ever rides on a real entry
    last_has_valid: assert property (@(posedge clk) disable iff (!res)
        out_last |-> out_entry.valid)
        else $error("out_last high without out_entry.valid");

    // a dropped histogram keeps the histogram number
    drop_keeps_num: assert property (@(posedge clk) disable iff (!res)
        hist_drop |-> (hist_num == $past(hist_num)))
        else $error("hist_num changed together with hist_drop");

    // drop is a single cycle pulse
    drop_single: assert property (@(posedge clk) disable iff (!res)
        hist_drop |=> !hist_drop)
        else $error("hist_drop high for two cycles in a row");

endmodule

bind hist_top hist_chk i_hist_chk (
    .clk       (clk),
    .res       (res),
    .out_entry (out_entry),
    .out_last  (out_last),
    .hist_num  (hist_num),
    .hist_drop (hist_drop)
);

`default_nettype wire

/* tests/hist_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hist_cfg.svh"

module hist_tb
    import hist_word_pkg::*, hist_op_pkg::*;
();

    localparam int PERIOD     = 8;
    localparam int RESET_CYC  = 4;
    localparam int SEGMENTS   = 40;
    localparam int SHORT_MIN  = 3;
    localparam int SHORT_SPAN = 28;
    localparam int LONG_MIN   = 120;
    localparam int LONG_SPAN  = 280;
    localparam int DRAIN_CYC  = 200;
    // two phases of worst case segments, twice over
    localparam int STIM_CYC   = 2 * (RESET_CYC + SEGMENTS * (LONG_MIN + LONG_SPAN)) + DRAIN_CYC;
    localparam int TIMEOUT_NS = 2 * STIM_CYC * PERIOD;
    localparam int SAT        = (1 << `HIST_COUNT_W) - 1;
    localparam int ENTRIES    = `HIST_PIXELS * `HIST_BINS;
    // hot spot so that some counters saturate
    localparam int HOT_PIXEL  = 2;
    localparam int HOT_BIN    = 5;

    // one expected readout entry and the cycle it shows up
    typedef struct packed {
        int       due;
        logic     last;
        hist_rd_t entry;
    } exp_entry_t;

    logic       clk;
    logic       res;
    logic       word_strobe;
    hist_word_u word;
    hist_rd_t   out_entry;
    logic       out_last;
    logic       hist_num;
    logic       hist_drop;

    integer     seed;

    // reference model state
    int         acc [`HIST_PIXELS][`HIST_BINS];
    int         acq = 0;
    int         cyc = 0;
    int         busy_end = -1;
    logic       m_num = 1'b0;
    logic       m_drop = 1'b0;
    logic       p_strobe = 1'b0;
    hist_word_u p_word;
    exp_entry_t exp_q [$];
    int         n_swaps = 0;
    int         n_drops = 0;
    int         n_sat = 0;
    int         n_checks = 0;
    int         n_mismatch = 0;
    int         n_other = 0;

    hist_top i_hist_top (
        .clk         (clk),
        .res         (res),
        .word_strobe (word_strobe),
        .word        (word),
        .out_entry   (out_entry),
        .out_last    (out_last),
        .hist_num    (hist_num),
        .hist_drop   (hist_drop)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    function automatic int pick(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic void clear_acc();
        for (int p = 0; p < `HIST_PIXELS; p++) begin
            for (int b = 0; b < `HIST_BINS; b++) begin
                acc[p][b] = 0;
            end
        end
    endfunction

    // histogram complete, queue its readout or discard it when busy
    function automatic void close_hist();
        exp_entry_t e;
        acq = 0;
        if (cyc <= busy_end) begin
            m_drop = 1'b1;
            n_drops++;
        end else begin
            m_num = ~m_num;
            n_swaps++;
            // busy through the edge that shows the last entry
            busy_end = cyc + ENTRIES + 1;
            for (int p = 0; p < `HIST_PIXELS; p++) begin
                for (int b = 0; b < `HIST_BINS; b++) begin
                    e.due         = cyc + 2 + p * `HIST_BINS + b;
                    e.last        = (p == `HIST_PIXELS - 1) && (b == `HIST_BINS - 1);
                    e.entry.valid = 1'b1;
                    e.entry.pixel = `HIST_PIXEL_W'(p);
                    e.entry.bin   = `HIST_BIN_W'(b);
                    e.entry.count = `HIST_COUNT_W'(acc[p][b]);
                    if (acc[p][b] == SAT) begin
                        n_sat++;
                    end
                    exp_q.push_back(e);
                end
            end
        end
        clear_acc();
    endfunction

    function automatic void apply_word(input hist_word_u w);
        if (!w.evt.kind) begin
            if (acc[w.evt.pixel][w.evt.bin] < SAT) begin
                acc[w.evt.pixel][w.evt.bin]++;
            end
        end else if (w.mrk.code == MARK_FLUSH) begin
            close_hist();
        end else if (w.mrk.code == MARK_ACQ_END) begin
            if (acq == `HIST_ACQ_NUM - 1) begin
                close_hist();
            end else begin
                acq++;
            end
        end
        // other marker codes fall through untouched
    endfunction

    // one rising edge of the model, word takes effect one edge after capture
    function automatic void model_step();
        cyc++;
        m_drop = 1'b0;
        if (!res) begin
            clear_acc();
            acq      = 0;
            busy_end = -1;
            m_num    = 1'b0;
            p_strobe = 1'b0;
            exp_q.delete();
        end else begin
            if (p_strobe) begin
                apply_word(p_word);
            end
            p_strobe = word_strobe;
            p_word   = word;
        end
    endfunction

    task automatic check_outputs();
        exp_entry_t e;
        n_checks++;
        if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
            e = exp_q.pop_front();
            assert (out_entry == e.entry) else begin
                n_mismatch++;
                $display("Mismatch out_entry cycle %0d: got %h expected %h",
                         cyc, out_entry, e.entry);
            end
            assert (out_last == e.last) else begin
                n_mismatch++;
                $display("Mismatch out_last cycle %0d: got %h expected %h", cyc, out_last, e.last);
            end
        end else begin
            assert (!out_entry.valid && !out_last) else begin
                n_mismatch++;
                $display("Mismatch out_entry.valid/out_last cycle %0d: got %h/%h expected 0/0",
                         cyc, out_entry.valid, out_last);
            end
        end
        assert (hist_num == m_num) else begin
            n_mismatch++;
            $display("Mismatch hist_num cycle %0d: got %h expected %h", cyc, hist_num, m_num);
        end
        assert (hist_drop == m_drop) else begin
            n_mismatch++;
            $display("Mismatch hist_drop cycle %0d: got %h expected %h", cyc, hist_drop, m_drop);
        end
    endtask

    // model on the edge, compare once the outputs have settled
    always begin
        @(posedge clk);
        model_step();
        #2;
        check_outputs();
    end

    task automatic reset_dut();
        res         = 1'b0;
        word_strobe = 1'b0;
        repeat (RESET_CYC) @(negedge clk);
        res = 1'b1;
    endtask

    // mostly events piling onto the hot bins, some idle cycles with junk on word
    task automatic drive_filler();
        logic [31:0] r;
        @(negedge clk);
        r           = $random(seed);
        word        = r[$bits(hist_word_u)-1:0];
        word_strobe = 1'b0;
        if (pick(4) != 0) begin
            word_strobe   = 1'b1;
            word.evt.kind = 1'b0;
            if (pick(4) != 0) begin
                word.evt.pixel = `HIST_PIXEL_W'(HOT_PIXEL);
                word.evt.bin   = `HIST_BIN_W'(HOT_BIN + pick(2));
            end else begin
                word.evt.pixel = `HIST_PIXEL_W'(pick(`HIST_PIXELS));
                word.evt.bin   = `HIST_BIN_W'(pick(`HIST_BINS));
            end
        end
    endtask

    // acq end mostly, some flush, some unknown codes
    task automatic drive_marker();
        logic [31:0] r;
        int          sel;
        @(negedge clk);
        r             = $random(seed);
        sel           = pick(20);
        word          = r[$bits(hist_word_u)-1:0];
        word.mrk.kind = 1'b1;
        if (sel < 14) begin
            word.mrk.code = MARK_ACQ_END;
        end else if (sel < 17) begin
            word.mrk.code = MARK_FLUSH;
        end else begin
            word.mrk.code = 3'(2 + pick(6));
        end
        word_strobe = 1'b1;
    endtask

    // short gaps land swaps inside the busy window, long ones outside
    task automatic run_phase();
        int gap;
        for (int s = 0; s < SEGMENTS; s++) begin
            if (pick(2) == 0) begin
                gap = SHORT_MIN + pick(SHORT_SPAN);
            end else begin
                gap = LONG_MIN + pick(LONG_SPAN);
            end
            repeat (gap) drive_filler();
            drive_marker();
        end
    endtask

    task automatic drive_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            word_strobe = 1'b0;
        end
    endtask

    initial begin
        seed = 88222;
        word = '0;
        reset_dut();
        run_phase();
        // reset in the middle of traffic, maybe during a readout
        reset_dut();
        run_phase();
        drive_idle(DRAIN_CYC);
        if (exp_q.size() != 0) begin
            n_other++;
            $display("readout stopped early, %0d entries never appeared", exp_q.size());
        end
        if (n_swaps == 0 || n_drops == 0 || n_sat == 0) begin
            n_other++;
            $display("stimulus missed a case: %0d swaps, %0d drops, %0d saturated entries",
                     n_swaps, n_drops, n_sat);
        end
        $display("checks %0d, mismatches %0d, other errors %0d", n_checks, n_mismatch, n_other);
        if (n_mismatch == 0 && n_other == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired at %0t, stimulus never finished", $time);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+include
src/hist_word_pkg.sv
src/hist_op_pkg.sv
src/hist_decode.sv
src/hist_execute.sv
src/hist_result.sv
src/hist_top.sv
tests/hist_chk.sv
tests/hist_tb.sv

/* run.sh */
#!/bin/sh
# build the histogram testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module hist_tb -f src.f -o hist_sim
out=$(./obj_dir/hist_sim)
echo "$out"
echo "$out" | grep -q "All tests passed"
